// File: include/bootrom_image.svh
// #########################################################################
// Boot ROM image
// #########################################################################

function automatic logic [tile_pkg::DATA_W-1:0] boot_word(
   input logic [tile_pkg::ROM_AW-1:0] idx
);
   case (idx)
      4'h0: boot_word = 32'h1800_0000;
      4'h1: boot_word = 32'ha820_0000;
      4'h2: boot_word = 32'h1860_0001;
      4'h3: boot_word = 32'ha863_0100;
      4'h4: boot_word = 32'h9c21_fffc;
      4'h5: boot_word = 32'hd401_1800;
      4'h6: boot_word = 32'h8481_0000;
      4'h7: boot_word = 32'he064_1804;
      4'h8: boot_word = 32'hbc04_0000;
      4'h9: boot_word = 32'h1000_0004;
      4'ha: boot_word = 32'h1500_0000;
      4'hb: boot_word = 32'h4400_4800;
      4'hc: boot_word = 32'h9d60_0000;
      4'hd: boot_word = 32'hdead_b007;
      4'he: boot_word = 32'h0000_0f0e;
      4'hf: boot_word = 32'hc0de_cafe;
   endcase
endfunction

// File: verilog/tile_pkg.sv
// #########################################################################
// Tile memory map and shared types
// #########################################################################

`default_nettype none

package tile_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int SEL_W      = DATA_W / 8;

   localparam int LMEM_WORDS = 256;
   localparam int LMEM_AW    = $clog2(LMEM_WORDS);
   localparam int LMEM_BYTES = LMEM_WORDS * SEL_W;       // Size of region 0 window

   localparam int ROM_WORDS  = 16;
   localparam int ROM_AW     = $clog2(ROM_WORDS);

   // Top nibble range match, as on the tile bus
   localparam logic [3:0] REGION_LMEM = 4'h0;
   localparam logic [3:0] REGION_BOOT = 4'hf;

   // Response code of the last pipeline stage
   typedef enum logic [1:0] {
      RESP_NONE = 2'd0,
      RESP_ACK  = 2'd1,
      RESP_ERR  = 2'd2
   } resp_e;

   // One bus address, seen either as region + offset or as a memory word
   typedef union packed {
      struct packed {
         logic [3:0]  region;
         logic [27:0] offset;
      } rgn;
      struct packed {
         logic [21:0]        upper;
         logic [LMEM_AW-1:0] word_idx;
         logic [1:0]         byte_off;                     // Ignored, word access only
      } mem;
   } tile_addr_u;

endpackage

`default_nettype wire

// File: verilog/wb_req_capture.sv
// #########################################################################
// Wishbone request capture
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module wb_req_capture (
   input  wire logic                        clk,
   input  wire logic                        rst_n_i,
   input  wire logic                        cyc_i,
   input  wire logic                        stb_i,
   input  wire logic                        we_i,
   input  wire logic [tile_pkg::ADDR_W-1:0] adr_i,
   input  wire logic [tile_pkg::DATA_W-1:0] dat_i,
   input  wire logic [tile_pkg::SEL_W-1:0]  sel_i,
   input  wire logic                        done_i,
   output      logic                        req_vld_o,
   output      logic                        req_we_o,
   output      tile_pkg::tile_addr_u        req_adr_o,
   output      logic [tile_pkg::DATA_W-1:0] req_dat_o,
   output      logic [tile_pkg::SEL_W-1:0]  req_sel_o
);

   logic busy;
   logic taken_q;                                        // Request latched at E
   logic accept;

   assign accept = cyc_i & stb_i & ~busy;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy      <= 1'b0;
         taken_q   <= 1'b0;
         req_vld_o <= 1'b0;
      end else begin
         taken_q   <= accept;
         req_vld_o <= taken_q;                           // Strobe one cycle after E
         if (done_i) begin
            busy <= 1'b0;
         end else if (accept) begin
            busy <= 1'b1;
         end
      end
   end

   // Fields stay put while busy
   always_ff @(posedge clk) begin
      if (accept) begin
         req_we_o  <= we_i;
         req_adr_o <= adr_i;
         req_dat_o <= dat_i;
         req_sel_o <= sel_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/addr_decode.sv
// #########################################################################
// Address region decode
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module addr_decode (
   input  wire logic                         clk,
   input  wire logic                         rst_n_i,
   input  wire logic                         req_vld_i,
   input  wire logic                         req_we_i,
   input  wire tile_pkg::tile_addr_u         req_adr_i,
   input  wire logic [tile_pkg::DATA_W-1:0]  req_dat_i,
   input  wire logic [tile_pkg::SEL_W-1:0]   req_sel_i,
   output      logic                         lmem_stb_o,
   output      logic                         rom_stb_o,
   output      logic                         err_pend_o,
   output      logic                         acc_we_o,
   output      logic [tile_pkg::LMEM_AW-1:0] acc_idx_o,
   output      logic [tile_pkg::DATA_W-1:0]  acc_dat_o,
   output      logic [tile_pkg::SEL_W-1:0]   acc_sel_o
);

   import tile_pkg::*;

   logic hit_lmem;
   logic hit_rom;

   // Region 0 only up to the end of the data memory
   assign hit_lmem = (req_adr_i.rgn.region == REGION_LMEM) &&
                     (req_adr_i.rgn.offset < 28'(LMEM_BYTES));

   // Boot ROM is read-only
   assign hit_rom = (req_adr_i.rgn.region == REGION_BOOT) && !req_we_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lmem_stb_o <= 1'b0;
         rom_stb_o  <= 1'b0;
         err_pend_o <= 1'b0;
      end else begin
         lmem_stb_o <= req_vld_i & hit_lmem;
         rom_stb_o  <= req_vld_i & hit_rom;
         err_pend_o <= req_vld_i & ~hit_lmem & ~hit_rom;  // Unmapped or ROM write
      end
   end

   always_ff @(posedge clk) begin
      if (req_vld_i) begin
         acc_we_o  <= req_we_i;
         acc_idx_o <= req_adr_i.mem.word_idx;
         acc_dat_o <= req_dat_i;
         acc_sel_o <= req_sel_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/lmem_sram.sv
// #########################################################################
// Local data memory
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module lmem_sram (
   input  wire logic                         clk,
   input  wire logic                         stb_i,
   input  wire logic                         we_i,
   input  wire logic [tile_pkg::LMEM_AW-1:0] idx_i,
   input  wire logic [tile_pkg::DATA_W-1:0]  dat_i,
   input  wire logic [tile_pkg::SEL_W-1:0]   sel_i,
   output      logic [tile_pkg::DATA_W-1:0]  rdat_o
);

   import tile_pkg::*;

   logic [DATA_W-1:0] mem [LMEM_WORDS];

   // Byte lanes written one by one
   always_ff @(posedge clk) begin
      if (stb_i && we_i) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (sel_i[b]) begin
               mem[idx_i][b*8 +: 8] <= dat_i[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i && !we_i) begin
         rdat_o <= mem[idx_i];                           // Registered read port
      end
   end

endmodule

`default_nettype wire

// File: verilog/boot_rom.sv
// #########################################################################
// Boot ROM
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module boot_rom (
   input  wire logic                        clk,
   input  wire logic                        stb_i,
   input  wire logic [tile_pkg::ROM_AW-1:0] idx_i,
   output      logic [tile_pkg::DATA_W-1:0] rdat_o
);

`include "bootrom_image.svh"

   // Image word fetched on a read strobe
   always_ff @(posedge clk) begin
      if (stb_i) begin
         rdat_o <= boot_word(idx_i);
      end
   end

endmodule

`default_nettype wire

// File: verilog/resp_mux.sv
// #########################################################################
// Response select
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module resp_mux (
   input  wire logic                        clk,
   input  wire logic                        rst_n_i,
   input  wire logic                        lmem_stb_i,
   input  wire logic                        rom_stb_i,
   input  wire logic                        err_pend_i,
   input  wire logic                        acc_we_i,
   input  wire logic [tile_pkg::DATA_W-1:0] lmem_rdat_i,
   input  wire logic [tile_pkg::DATA_W-1:0] rom_rdat_i,
   output      logic                        ack_o,
   output      logic                        err_o,
   output      logic [tile_pkg::DATA_W-1:0] dat_o,
   output      logic                        done_o
);

   import tile_pkg::*;

   resp_e resp_q;
   logic  rd_lmem_q;                                     // Data memory read pending
   logic  rd_rom_q;                                      // Boot ROM read pending

   // Same edge as the slave read registers
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         resp_q    <= RESP_NONE;
         rd_lmem_q <= 1'b0;
         rd_rom_q  <= 1'b0;
      end else begin
         rd_lmem_q <= lmem_stb_i & ~acc_we_i;
         rd_rom_q  <= rom_stb_i;
         if (err_pend_i) begin
            resp_q <= RESP_ERR;
         end else if (lmem_stb_i || rom_stb_i) begin
            resp_q <= RESP_ACK;
         end else begin
            resp_q <= RESP_NONE;
         end
      end
   end

   assign ack_o  = (resp_q == RESP_ACK);
   assign err_o  = (resp_q == RESP_ERR);
   assign done_o = ack_o | err_o;                        // Frees the capture stage

   // Write ack and err carry zero data
   always_comb begin
      dat_o = '0;
      if (rd_lmem_q) begin
         dat_o = lmem_rdat_i;
      end else if (rd_rom_q) begin
         dat_o = rom_rdat_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tile_mem_top.sv
// #########################################################################
// Tile local memory subsystem
// #########################################################################

`timescale 1ns/1ps
`default_nettype none

module tile_mem_top (
   input  wire logic                        clk,
   input  wire logic                        rst_n_i,
   input  wire logic                        cyc_i,
   input  wire logic                        stb_i,
   input  wire logic                        we_i,
   input  wire logic [tile_pkg::ADDR_W-1:0] adr_i,
   input  wire logic [tile_pkg::DATA_W-1:0] dat_i,
   input  wire logic [tile_pkg::SEL_W-1:0]  sel_i,
   output      logic                        ack_o,
   output      logic                        err_o,
   output      logic [tile_pkg::DATA_W-1:0] dat_o
);

   import tile_pkg::*;

   // Capture to decode
   logic              req_vld;
   logic              req_we;
   tile_addr_u        req_adr;
   logic [DATA_W-1:0] req_dat;
   logic [SEL_W-1:0]  req_sel;
   logic              done;

   // Decode to slaves and response
   logic               lmem_stb;
   logic               rom_stb;
   logic               err_pend;
   logic               acc_we;
   logic [LMEM_AW-1:0] acc_idx;
   logic [DATA_W-1:0]  acc_dat;
   logic [SEL_W-1:0]   acc_sel;

   // Slave read data
   logic [DATA_W-1:0] lmem_rdat;
   logic [DATA_W-1:0] rom_rdat;

   wb_req_capture u_capture (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .adr_i     (adr_i),
      .dat_i     (dat_i),
      .sel_i     (sel_i),
      .done_i    (done),
      .req_vld_o (req_vld),
      .req_we_o  (req_we),
      .req_adr_o (req_adr),
      .req_dat_o (req_dat),
      .req_sel_o (req_sel)
   );

   addr_decode u_decode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .req_vld_i  (req_vld),
      .req_we_i   (req_we),
      .req_adr_i  (req_adr),
      .req_dat_i  (req_dat),
      .req_sel_i  (req_sel),
      .lmem_stb_o (lmem_stb),
      .rom_stb_o  (rom_stb),
      .err_pend_o (err_pend),
      .acc_we_o   (acc_we),
      .acc_idx_o  (acc_idx),
      .acc_dat_o  (acc_dat),
      .acc_sel_o  (acc_sel)
   );

   lmem_sram u_lmem (
      .clk    (clk),
      .stb_i  (lmem_stb),
      .we_i   (acc_we),
      .idx_i  (acc_idx),
      .dat_i  (acc_dat),
      .sel_i  (acc_sel),
      .rdat_o (lmem_rdat)
   );

   boot_rom u_bootrom (
      .clk    (clk),
      .stb_i  (rom_stb),
      .idx_i  (acc_idx[ROM_AW-1:0]),                     // ROM aliases within region f
      .rdat_o (rom_rdat)
   );

   resp_mux u_resp (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .lmem_stb_i  (lmem_stb),
      .rom_stb_i   (rom_stb),
      .err_pend_i  (err_pend),
      .acc_we_i    (acc_we),
      .lmem_rdat_i (lmem_rdat),
      .rom_rdat_i  (rom_rdat),
      .ack_o       (ack_o),
      .err_o       (err_o),
      .dat_o       (dat_o),
      .done_o      (done)
   );

endmodule

`default_nettype wire

// File: test/tile_mem_tb.sv
// ##########################################################################
// Tile local memory testbench
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tile_mem_tb;

   import tile_pkg::*;

`include "bootrom_image.svh"

   localparam int RST_CYCLES  = 10;
   localparam int MAX_ENTRIES = 48;
   localparam int LATENCY     = 3;                       // Edges from acceptance to response
   localparam int RESP_LIMIT  = 8;

   logic              clk;
   logic              rst_n_i;
   logic              cyc_i;
   logic              stb_i;
   logic              we_i;
   logic [ADDR_W-1:0] adr_i;
   logic [DATA_W-1:0] dat_i;
   logic [SEL_W-1:0]  sel_i;
   logic              ack_o;
   logic              err_o;
   logic [DATA_W-1:0] dat_o;

   // Request table, expected columns filled by the shadow model
   string             tc_name     [MAX_ENTRIES];
   logic              tc_we       [MAX_ENTRIES];
   logic [ADDR_W-1:0] tc_adr      [MAX_ENTRIES];
   logic [DATA_W-1:0] tc_dat      [MAX_ENTRIES];
   logic [SEL_W-1:0]  tc_sel      [MAX_ENTRIES];
   resp_e             tc_exp_resp [MAX_ENTRIES];
   logic [DATA_W-1:0] tc_exp_dat  [MAX_ENTRIES];

   logic [DATA_W-1:0] shadow_mem [LMEM_WORDS];
   logic [31:0]       rng_state = 32'd46;
   int                n_entries = 0;
   int                n_checks  = 0;
   int                errors    = 0;
   logic              table_built = 1'b0;

   tile_mem_top dut0 (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cyc_i   (cyc_i),
      .stb_i   (stb_i),
      .we_i    (we_i),
      .adr_i   (adr_i),
      .dat_i   (dat_i),
      .sel_i   (sel_i),
      .ack_o   (ack_o),
      .err_o   (err_o),
      .dat_o   (dat_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                            // 20 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [ADDR_W-1:0] lmem_addr(input logic [LMEM_AW-1:0] idx);
      return {REGION_LMEM, 18'd0, idx, 2'b00};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Appends one request and works out its response from the memory map
   task automatic add_entry(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [SEL_W-1:0] sel);
      logic [DATA_W-1:0]  wdat;
      logic [LMEM_AW-1:0] idx;
      wdat = '0;
      if (we) begin
         rng_state = xorshift32(rng_state);
         wdat      = rng_state;
      end
      idx = adr[LMEM_AW+1:2];
      tc_name[n_entries]    = name;
      tc_we[n_entries]      = we;
      tc_adr[n_entries]     = adr;
      tc_dat[n_entries]     = wdat;
      tc_sel[n_entries]     = sel;
      tc_exp_dat[n_entries] = '0;
      if (adr[31:28] == REGION_LMEM && adr[27:0] < 28'(LMEM_WORDS * SEL_W)) begin
         tc_exp_resp[n_entries] = RESP_ACK;
         if (we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (sel[b]) begin
                  shadow_mem[idx][b*8 +: 8] = wdat[b*8 +: 8];
               end
            end
         end else begin
            tc_exp_dat[n_entries] = shadow_mem[idx];
         end
      end else if (adr[31:28] == REGION_BOOT && !we) begin
         tc_exp_resp[n_entries] = RESP_ACK;
         tc_exp_dat[n_entries]  = boot_word(adr[ROM_AW+1:2]);
      end else begin
         tc_exp_resp[n_entries] = RESP_ERR;           // Unmapped or ROM write
      end
      n_entries++;
   endtask

   task automatic build_table();
      add_entry("wr_full_w000", 1'b1, lmem_addr(8'h00), 4'hf);
      add_entry("wr_full_w001", 1'b1, lmem_addr(8'h01), 4'hf);
      add_entry("wr_full_w07f", 1'b1, lmem_addr(8'h7f), 4'hf);
      add_entry("wr_full_w0ff", 1'b1, lmem_addr(8'hff), 4'hf);
      add_entry("rd_full_w000", 1'b0, lmem_addr(8'h00), 4'hf);
      add_entry("rd_full_w001", 1'b0, lmem_addr(8'h01), 4'hf);
      add_entry("rd_full_w07f", 1'b0, lmem_addr(8'h7f), 4'hf);
      add_entry("rd_full_w0ff", 1'b0, lmem_addr(8'hff), 4'hf);
      add_entry("wr_part_w001", 1'b1, lmem_addr(8'h01), 4'b0101);
      add_entry("wr_part_w07f", 1'b1, lmem_addr(8'h7f), 4'b1000);
      add_entry("wr_part_w0ff", 1'b1, lmem_addr(8'hff), 4'b0010);
      add_entry("wr_part_w000", 1'b1, lmem_addr(8'h00), 4'b0110);
      add_entry("rd_part_w001", 1'b0, lmem_addr(8'h01), 4'hf);
      add_entry("rd_part_w07f", 1'b0, lmem_addr(8'h7f), 4'hf);
      add_entry("rd_part_w0ff", 1'b0, lmem_addr(8'hff), 4'hf);
      add_entry("rd_part_w000", 1'b0, lmem_addr(8'h00), 4'hf);
      for (int r = 0; r < ROM_WORDS; r++) begin
         add_entry($sformatf("rd_rom_%0d", r), 1'b0, {REGION_BOOT, 28'(r * 4)}, 4'hf);
      end
      add_entry("err_rom_write", 1'b1, {REGION_BOOT, 28'h10}, 4'hf);
      add_entry("err_region_e_rd", 1'b0, 32'he000_0000, 4'hf);
      add_entry("err_region_e_wr", 1'b1, 32'he000_0040, 4'hf);
      add_entry("err_lmem_beyond_wr", 1'b1, 32'h0000_0400, 4'hf);  // Aliases word 0
      add_entry("err_lmem_beyond_rd", 1'b0, 32'h0fff_fffc, 4'hf);
      add_entry("rd_rom_after_write", 1'b0, {REGION_BOOT, 28'h10}, 4'hf);
      add_entry("rd_w000_after_beyond", 1'b0, lmem_addr(8'h00), 4'hf);
   endtask

   task automatic drive_idle();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      dat_i = '0;
      sel_i = '0;
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic run_request(input int i);
      int         lat;
      logic       seen;
      logic [1:0] exp_code;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = tc_we[i];
      adr_i = tc_adr[i];
      dat_i = tc_dat[i];
      sel_i = tc_sel[i];
      lat   = 0;
      seen  = 1'b0;
      while (!seen && lat < RESP_LIMIT) begin
         @(negedge clk);
         if (ack_o || err_o) begin
            seen = 1'b1;
         end else begin
            lat++;
         end
      end
      if (!seen) begin
         errors++;
         $display("No response from the DUT for request %s", tc_name[i]);
      end else begin
         exp_code = {tc_exp_resp[i] == RESP_ACK, tc_exp_resp[i] == RESP_ERR};
         check_value({tc_name[i], " latency"}, LATENCY, lat);
         check_value({tc_name[i], " ack/err"}, {30'd0, exp_code}, {30'd0, ack_o, err_o});
         check_value({tc_name[i], " data"}, tc_exp_dat[i], dat_o);
      end
      drive_idle();                                      // Master drops the request
      @(negedge clk);
      check_value({tc_name[i], " one-cycle response"}, 32'd0, {30'd0, ack_o, err_o});
   endtask

   initial begin
      rst_n_i = 1'b0;
      drive_idle();
      build_table();
      table_built = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      check_value("in_reset", 32'd0, {30'd0, ack_o, err_o});
      rst_n_i = 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_value("after_reset", 32'd0, {30'd0, ack_o, err_o});
      end
      for (int i = 0; i < n_entries; i++) begin
         run_request(i);
      end
      $display("Checks run: %0d, errors: %0d", n_checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Generous bound, each request needs about six cycles
   initial begin
      wait (table_built);
      repeat (n_entries * 10 + RST_CYCLES) @(posedge clk);
      $display("Timeout: the test did not finish within the expected number of cycles");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/tile_pkg.sv
verilog/wb_req_capture.sv
verilog/addr_decode.sv
verilog/lmem_sram.sv
verilog/boot_rom.sv
verilog/resp_mux.sv
verilog/tile_mem_top.sv
test/tile_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tile memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
   --top-module tile_mem_tb -o tile_mem_sim \
   || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tile_mem_sim)
echo "$sim_out"

echo "$sim_out" | grep -qx "ALL CHECKS PASSED" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }
